// File: source/mem_pkg.sv
package mem_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int REG_IDX_W  = 5;
    localparam int OFFSET_W   = 12;
    localparam int PN_W       = ADDR_W - OFFSET_W;
    localparam int PLV_W      = 2;
    localparam int EXCP_W     = 7;
    localparam int BYTE_LANES = DATA_W / 8;

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [ADDR_W-3:0]     word_addr_t;
    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [BYTE_LANES-1:0] byte_en_t;
    typedef logic [REG_IDX_W-1:0]  reg_idx_t;
    typedef logic [PN_W-1:0]       vppn_t;
    typedef logic [PN_W-1:0]       ppn_t;
    typedef logic [PLV_W-1:0]      plv_t;
    typedef logic [EXCP_W-1:0]     excp_vec_t;

    // Most restricted privilege level
    localparam plv_t USER_PLV = 2'd3;

    // Exception vector bit positions
    localparam int EXCP_IN   = 0;
    localparam int EXCP_ADEM = 1;
    localparam int EXCP_TLBR = 2;
    localparam int EXCP_PME  = 3;
    localparam int EXCP_PPI  = 4;
    localparam int EXCP_PIS  = 5;
    localparam int EXCP_PIL  = 6;

    typedef enum logic [3:0] {
        op_none,
        op_ld_b,
        op_ld_bu,
        op_ld_h,
        op_ld_hu,
        op_ld_w,
        op_st_b,
        op_st_h,
        op_st_w,
        op_ll_w,
        op_sc_w
    } mem_op_e;

    typedef struct packed {
        logic  e;
        vppn_t vppn;
        ppn_t  ppn;
        logic  v;
        logic  d;
        plv_t  plv;
    } tlb_entry_t;

    typedef struct packed {
        logic  found;
        logic  v;
        logic  d;
        plv_t  plv;
        addr_t paddr;
    } tlb_result_t;

    typedef struct packed {
        logic     valid;
        mem_op_e  op;
        addr_t    vaddr;
        word_t    reg2;
        logic     wreg;
        reg_idx_t waddr;
        word_t    wdata;
        logic     trans_en;
        logic     in_excp;
    } ex_mem_t;

    typedef struct packed {
        logic       ce;
        logic       we;
        word_addr_t addr;
        byte_en_t   sel;
        word_t      data;
    } dmem_req_t;

    typedef struct packed {
        logic      valid;
        mem_op_e   op;
        addr_t     paddr;
        logic      wreg;
        reg_idx_t  waddr;
        word_t     wdata;
        excp_vec_t excp;
    } mem1_mem2_t;

    typedef struct packed {
        logic     valid;
        logic     wreg;
        logic     ready;
        reg_idx_t waddr;
        word_t    wdata;
    } forward_t;

    typedef struct packed {
        logic      valid;
        logic      wreg;
        reg_idx_t  waddr;
        word_t     wdata;
        excp_vec_t excp;
    } wb_t;

endpackage

// File: source/dtlb.sv
module dtlb #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             we_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0]   windex_i,
    input  mem_pkg::tlb_entry_t              wentry_i,
    input  mem_pkg::addr_t                   vaddr_i,
    output mem_pkg::tlb_result_t             result_o
);

    mem_pkg::tlb_entry_t entries [TLB_ENTRIES];
    mem_pkg::vppn_t      lookup_vppn;
    mem_pkg::ppn_t       hit_ppn;
    logic                dup_hit;

    assign lookup_vppn = vaddr_i[mem_pkg::ADDR_W-1:mem_pkg::OFFSET_W];

    // Fill port, one entry per cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else if (we_i) begin
            entries[windex_i] <= wentry_i;
        end
    end

    // Walk downwards so the lowest matching index wins
    always_comb begin
        result_o = '0;
        hit_ppn  = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entries[i].e && entries[i].vppn == lookup_vppn) begin
                result_o.found = 1'b1;
                result_o.v     = entries[i].v;
                result_o.d     = entries[i].d;
                result_o.plv   = entries[i].plv;
                hit_ppn        = entries[i].ppn;
            end
        end
        result_o.paddr = {hit_ppn, vaddr_i[mem_pkg::OFFSET_W-1:0]};
    end

    // Any pair of live entries sharing a page number
    always_comb begin
        dup_hit = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            for (int j = i + 1; j < TLB_ENTRIES; j++) begin
                if (entries[i].e && entries[j].e && entries[i].vppn == entries[j].vppn) begin
                    dup_hit = 1'b1;
                end
            end
        end
    end

    a_no_dup_vppn: assert property (@(posedge clk) disable iff (rst) !dup_hit)
        else $error("dtlb: two valid entries map the same vppn");

endmodule

// File: source/mem1_stage.sv
module mem1_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush_i,
    input  logic                  advance_i,
    input  mem_pkg::ex_mem_t      ex_i,
    input  mem_pkg::plv_t         csr_plv_i,
    input  mem_pkg::tlb_result_t  tlb_i,
    input  logic                  dmem_ready_i,
    input  logic                  dmem_ack_i,
    input  logic                  llbit_i,
    output logic                  advance_ready_o,
    output mem_pkg::dmem_req_t    dmem_req_o,
    output logic                  llbit_we_o,
    output logic                  llbit_value_o,
    output mem_pkg::forward_t     forward_o,
    output mem_pkg::mem1_mem2_t   mem2_o
);

    mem_pkg::addr_t      paddr;
    mem_pkg::excp_vec_t  excp;
    mem_pkg::mem1_mem2_t rec;
    logic                is_load;
    logic                is_store;
    logic                load_op;
    logic                store_op;
    logic                access_mem;
    logic                sc_fail;
    logic                mem_access;

    assign paddr = ex_i.trans_en ? tlb_i.paddr : ex_i.vaddr;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        case (ex_i.op)
            mem_pkg::op_ld_b, mem_pkg::op_ld_bu, mem_pkg::op_ld_h, mem_pkg::op_ld_hu,
            mem_pkg::op_ld_w, mem_pkg::op_ll_w: is_load = 1'b1;
            mem_pkg::op_st_b, mem_pkg::op_st_h, mem_pkg::op_st_w,
            mem_pkg::op_sc_w: is_store = 1'b1;
            default: ;
        endcase
    end

    assign load_op    = ex_i.valid && is_load;
    assign store_op   = ex_i.valid && is_store;
    assign access_mem = load_op || store_op;

    // Translation and privilege checks
    assign excp[mem_pkg::EXCP_IN]   = ex_i.valid && ex_i.in_excp;
    assign excp[mem_pkg::EXCP_ADEM] = access_mem && (csr_plv_i == mem_pkg::USER_PLV)
                                      && ex_i.vaddr[mem_pkg::ADDR_W-1];
    assign excp[mem_pkg::EXCP_TLBR] = access_mem && ex_i.trans_en && !tlb_i.found;
    assign excp[mem_pkg::EXCP_PIL]  = load_op && ex_i.trans_en && !tlb_i.v;
    assign excp[mem_pkg::EXCP_PIS]  = store_op && ex_i.trans_en && !tlb_i.v;
    assign excp[mem_pkg::EXCP_PPI]  = access_mem && ex_i.trans_en && tlb_i.v
                                      && (csr_plv_i > tlb_i.plv);
    assign excp[mem_pkg::EXCP_PME]  = store_op && ex_i.trans_en && tlb_i.v
                                      && (csr_plv_i <= tlb_i.plv) && !tlb_i.d;

    // A failing sc_w never touches memory
    assign sc_fail    = (ex_i.op == mem_pkg::op_sc_w) && !llbit_i;
    assign mem_access = access_mem && (excp == '0) && !sc_fail;

    assign advance_ready_o = !mem_access || dmem_ack_i;

    always_comb begin
        dmem_req_o = '0;
        if (mem_access && dmem_ready_i) begin
            dmem_req_o.ce   = 1'b1;
            dmem_req_o.addr = paddr[mem_pkg::ADDR_W-1:2];
            case (ex_i.op)
                mem_pkg::op_ld_b, mem_pkg::op_ld_bu: begin
                    dmem_req_o.sel = 4'b0001 << paddr[1:0];
                end
                mem_pkg::op_ld_h, mem_pkg::op_ld_hu: begin
                    dmem_req_o.sel = 4'b0011 << paddr[1:0];
                end
                mem_pkg::op_st_b: begin
                    dmem_req_o.we   = 1'b1;
                    dmem_req_o.sel  = 4'b0001 << paddr[1:0];
                    dmem_req_o.data = mem_pkg::word_t'(ex_i.reg2[7:0]) << {paddr[1:0], 3'b000};
                end
                mem_pkg::op_st_h: begin
                    dmem_req_o.we   = 1'b1;
                    dmem_req_o.sel  = 4'b0011 << paddr[1:0];
                    dmem_req_o.data = mem_pkg::word_t'(ex_i.reg2[15:0]) << {paddr[1:0], 3'b000};
                end
                mem_pkg::op_st_w, mem_pkg::op_sc_w: begin
                    dmem_req_o.we   = 1'b1;
                    dmem_req_o.sel  = 4'b1111;
                    dmem_req_o.data = ex_i.reg2;
                end
                default: begin
                    // ld_w and ll_w read the whole word
                    dmem_req_o.sel = 4'b1111;
                end
            endcase
        end
    end

    // Record for mem2 and link bit update
    always_comb begin
        rec.valid     = ex_i.valid;
        rec.op        = ex_i.op;
        rec.paddr     = paddr;
        rec.wreg      = ex_i.wreg;
        rec.waddr     = ex_i.waddr;
        rec.wdata     = ex_i.wdata;
        rec.excp      = excp;
        llbit_we_o    = 1'b0;
        llbit_value_o = 1'b0;
        if (access_mem && excp == '0) begin
            case (ex_i.op)
                mem_pkg::op_ll_w: begin
                    llbit_we_o    = advance_i;
                    llbit_value_o = 1'b1;
                end
                mem_pkg::op_sc_w: begin
                    rec.wreg  = 1'b1;
                    rec.wdata = mem_pkg::word_t'(llbit_i);
                    // Success consumes the link
                    llbit_we_o = advance_i && llbit_i;
                end
                default: ;
            endcase
        end
    end

    // Load data is not known until mem2
    assign forward_o.valid = ex_i.valid;
    assign forward_o.wreg  = rec.wreg;
    assign forward_o.ready = !is_load;
    assign forward_o.waddr = rec.waddr;
    assign forward_o.wdata = rec.wdata;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            mem2_o <= '0;
        end else if (advance_i) begin
            mem2_o <= rec;
        end
    end

    a_advance_when_ready: assert property (@(posedge clk) disable iff (rst)
        advance_i |-> advance_ready_o)
        else $error("mem1_stage: advance raised while a memory access is outstanding");

endmodule

// File: source/data_mem.sv
module data_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic                clk,
    input  logic                rst,
    input  mem_pkg::dmem_req_t  req_i,
    output logic                ready_o,
    output logic                ack_o,
    output mem_pkg::word_t      rdata_o,
    input  logic                llbit_we_i,
    input  logic                llbit_value_i,
    output logic                llbit_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    mem_pkg::word_t   mem [MEM_WORDS];
    mem_pkg::word_t   rdata_q;
    logic [IDX_W-1:0] idx;
    logic             accept;
    logic             ack_q;
    logic             llbit_q;

    // Word index wraps at the array size
    assign idx     = req_i.addr[IDX_W-1:0];
    assign ready_o = !ack_q;
    assign accept  = req_i.ce && ready_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (accept && req_i.we) begin
            for (int b = 0; b < mem_pkg::BYTE_LANES; b++) begin
                if (req_i.sel[b]) begin
                    mem[idx][8*b +: 8] <= req_i.data[8*b +: 8];
                end
            end
        end
    end

    // Returns the word as it was before a write in the same cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q   <= 1'b0;
            llbit_q <= 1'b0;
        end else begin
            ack_q <= accept;
            if (llbit_we_i) begin
                llbit_q <= llbit_value_i;
            end
        end
    end

    assign ack_o   = ack_q;
    assign rdata_o = rdata_q;
    assign llbit_o = llbit_q;

    a_write_has_lanes: assert property (@(posedge clk) disable iff (rst)
        (req_i.ce && req_i.we) |-> (req_i.sel != '0))
        else $error("data_mem: write request without byte enables");

endmodule

// File: source/mem2_stage.sv
module mem2_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush_i,
    input  logic                 advance_i,
    input  mem_pkg::mem1_mem2_t  mem1_i,
    input  mem_pkg::word_t       rdata_i,
    output mem_pkg::wb_t         wb_o
);

    mem_pkg::word_t rdata_q;
    mem_pkg::word_t shifted;
    mem_pkg::word_t result;

    // Word returned in the ack cycle of this instruction
    always_ff @(posedge clk) begin
        if (advance_i) begin
            rdata_q <= rdata_i;
        end
    end

    assign shifted = rdata_q >> {mem1_i.paddr[1:0], 3'b000};

    always_comb begin
        case (mem1_i.op)
            mem_pkg::op_ld_b: begin
                result = {{24{shifted[7]}}, shifted[7:0]};
            end
            mem_pkg::op_ld_bu: begin
                result = {24'b0, shifted[7:0]};
            end
            mem_pkg::op_ld_h: begin
                result = {{16{shifted[15]}}, shifted[15:0]};
            end
            mem_pkg::op_ld_hu: begin
                result = {16'b0, shifted[15:0]};
            end
            mem_pkg::op_ld_w, mem_pkg::op_ll_w: begin
                result = rdata_q;
            end
            default: begin
                result = mem1_i.wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wb_o <= '0;
        end else if (advance_i) begin
            wb_o.valid <= mem1_i.valid;
            // Excepting instructions never write the register file
            wb_o.wreg  <= mem1_i.wreg && (mem1_i.excp == '0);
            wb_o.waddr <= mem1_i.waddr;
            wb_o.wdata <= result;
            wb_o.excp  <= mem1_i.excp;
        end
    end

endmodule

// File: source/mem_subsys_top.sv
module mem_subsys_top #(
    parameter int TLB_ENTRIES = 8,
    parameter int MEM_WORDS   = 256
) (
    input  logic                            clk,
    input  logic                            rst,
    input  mem_pkg::ex_mem_t                ex_i,
    input  logic                            advance_i,
    input  logic                            flush_i,
    input  mem_pkg::plv_t                   csr_plv_i,
    input  logic                            tlb_we_i,
    input  logic [$clog2(TLB_ENTRIES)-1:0]  tlb_windex_i,
    input  mem_pkg::tlb_entry_t             tlb_wentry_i,
    output logic                            advance_ready_o,
    output mem_pkg::forward_t               forward_o,
    output mem_pkg::wb_t                    wb_o
);

    mem_pkg::tlb_result_t tlb_result;
    mem_pkg::dmem_req_t   dmem_req;
    mem_pkg::word_t       dmem_rdata;
    mem_pkg::mem1_mem2_t  mem1_mem2;
    logic                 dmem_ready;
    logic                 dmem_ack;
    logic                 llbit;
    logic                 llbit_we;
    logic                 llbit_value;

    dtlb #(
        .TLB_ENTRIES(TLB_ENTRIES)
    ) dtlb_inst (
        .clk     (clk),
        .rst     (rst),
        .we_i    (tlb_we_i),
        .windex_i(tlb_windex_i),
        .wentry_i(tlb_wentry_i),
        .vaddr_i (ex_i.vaddr),
        .result_o(tlb_result)
    );

    mem1_stage mem1_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (flush_i),
        .advance_i      (advance_i),
        .ex_i           (ex_i),
        .csr_plv_i      (csr_plv_i),
        .tlb_i          (tlb_result),
        .dmem_ready_i   (dmem_ready),
        .dmem_ack_i     (dmem_ack),
        .llbit_i        (llbit),
        .advance_ready_o(advance_ready_o),
        .dmem_req_o     (dmem_req),
        .llbit_we_o     (llbit_we),
        .llbit_value_o  (llbit_value),
        .forward_o      (forward_o),
        .mem2_o         (mem1_mem2)
    );

    data_mem #(
        .MEM_WORDS(MEM_WORDS)
    ) data_mem_inst (
        .clk          (clk),
        .rst          (rst),
        .req_i        (dmem_req),
        .ready_o      (dmem_ready),
        .ack_o        (dmem_ack),
        .rdata_o      (dmem_rdata),
        .llbit_we_i   (llbit_we),
        .llbit_value_i(llbit_value),
        .llbit_o      (llbit)
    );

    mem2_stage mem2_stage_inst (
        .clk      (clk),
        .rst      (rst),
        .flush_i  (flush_i),
        .advance_i(advance_i),
        .mem1_i   (mem1_mem2),
        .rdata_i  (dmem_rdata),
        .wb_o     (wb_o)
    );

endmodule

// File: dv/mem_subsys_tb.sv
module mem_subsys_tb;

    localparam int TLB_ENTRIES = 8;
    localparam int MEM_WORDS   = 4096;
    localparam int IDX_W       = $clog2(TLB_ENTRIES);

    logic                 clk;
    logic                 rst;
    mem_pkg::ex_mem_t     ex;
    logic                 advance;
    logic                 flush;
    mem_pkg::plv_t        csr_plv;
    logic                 tlb_we;
    logic [IDX_W-1:0]     tlb_windex;
    mem_pkg::tlb_entry_t  tlb_wentry;
    logic                 advance_ready;
    mem_pkg::forward_t    forward;
    mem_pkg::wb_t         wb;

    string        lines [$];
    mem_pkg::wb_t exp_q [$];
    string        name_q [$];
    int           errors;
    int           cycles;
    int           cycle_limit;

    // Large enough that page number bits reach the word index
    mem_subsys_top #(
        .TLB_ENTRIES(TLB_ENTRIES),
        .MEM_WORDS  (MEM_WORDS)
    ) mem_subsys_top_inst (
        .clk            (clk),
        .rst            (rst),
        .ex_i           (ex),
        .advance_i      (advance),
        .flush_i        (flush),
        .csr_plv_i      (csr_plv),
        .tlb_we_i       (tlb_we),
        .tlb_windex_i   (tlb_windex),
        .tlb_wentry_i   (tlb_wentry),
        .advance_ready_o(advance_ready),
        .forward_o      (forward),
        .wb_o           (wb)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic mem_pkg::mem_op_e op_from_name(input string s);
        mem_pkg::mem_op_e op;
        case (s)
            "ld_b":  op = mem_pkg::op_ld_b;
            "ld_bu": op = mem_pkg::op_ld_bu;
            "ld_h":  op = mem_pkg::op_ld_h;
            "ld_hu": op = mem_pkg::op_ld_hu;
            "ld_w":  op = mem_pkg::op_ld_w;
            "st_b":  op = mem_pkg::op_st_b;
            "st_h":  op = mem_pkg::op_st_h;
            "st_w":  op = mem_pkg::op_st_w;
            "ll_w":  op = mem_pkg::op_ll_w;
            "sc_w":  op = mem_pkg::op_sc_w;
            default: op = mem_pkg::op_none;
        endcase
        return op;
    endfunction

    task automatic report_mismatch(input string name, input string what,
                                   input string want_s, input string got_s);
        errors++;
        $display("CHECK FAILED %s %s: expected %s, actual %s", name, what, want_s, got_s);
    endtask

    task automatic read_patterns(output bit ok);
        int    fd;
        string line;
        ok = 1'b0;
        fd = $fopen("dv/mem_patterns.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0) begin
                    if (line.len() > 1 && line.substr(0, 0) != "#") begin
                        lines.push_back(line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic fill_tlb(input string line);
        string               kind;
        int                  idx;
        int                  n;
        logic                e;
        mem_pkg::vppn_t      vppn;
        mem_pkg::ppn_t       ppn;
        logic                v;
        logic                d;
        mem_pkg::plv_t       plv;
        mem_pkg::tlb_entry_t entry;
        n = $sscanf(line, "%s %h %h %h %h %h %h %h", kind, idx, e, vppn, ppn, v, d, plv);
        if (n != 8) begin
            errors++;
            $display("Malformed TLB line in pattern file: %s", line);
        end else begin
            entry.e    = e;
            entry.vppn = vppn;
            entry.ppn  = ppn;
            entry.v    = v;
            entry.d    = d;
            entry.plv  = plv;
            @(posedge clk);
            tlb_we     <= 1'b1;
            tlb_windex <= idx[IDX_W-1:0];
            tlb_wentry <= entry;
            @(posedge clk);
            tlb_we <= 1'b0;
        end
    endtask

    // One instruction: a hold cycle, then the advance cycle
    task automatic run_instr(input string line);
        string              kind;
        string              name;
        string              op_name;
        mem_pkg::ex_mem_t   instr;
        mem_pkg::addr_t     vaddr;
        mem_pkg::word_t     reg2;
        logic               wreg;
        mem_pkg::reg_idx_t  waddr;
        mem_pkg::word_t     wdata;
        logic               trans_en;
        logic               in_excp;
        mem_pkg::wb_t       exp_wb;
        mem_pkg::wb_t       held;
        mem_pkg::plv_t      plv;
        mem_pkg::excp_vec_t exp_excp;
        mem_pkg::word_t     exp_wdata;
        logic               exp_ready;
        logic               access;
        int                 n;
        instr = '0;
        n = $sscanf(line, "%s %s %s %h %h %h %h %h %h %h %h %h %h %h", kind, name, op_name,
                    vaddr, reg2, wreg, waddr, wdata, trans_en, in_excp, plv,
                    exp_wdata, exp_excp, exp_ready);
        if (n != 14) begin
            errors++;
            $display("Malformed instruction line in pattern file: %s", line);
        end else begin
            instr.vaddr    = vaddr;
            instr.reg2     = reg2;
            instr.wreg     = wreg;
            instr.waddr    = waddr;
            instr.wdata    = wdata;
            instr.trans_en = trans_en;
            instr.in_excp  = in_excp;
            instr.valid    = (kind != "B");
            instr.op       = op_from_name(op_name);
            exp_wb.valid   = instr.valid;
            exp_wb.excp    = exp_excp;
            // sc_w always writes its flag, exceptions never write
            exp_wb.wreg  = (exp_excp == '0) && ((instr.op == mem_pkg::op_sc_w) || instr.wreg);
            exp_wb.waddr = instr.waddr;
            exp_wb.wdata = exp_wdata;
            access = instr.valid && (instr.op != mem_pkg::op_none) && (exp_excp == '0)
                     && !((instr.op == mem_pkg::op_sc_w) && (exp_wdata == '0));

            @(posedge clk);
            ex      <= instr;
            csr_plv <= plv;
            advance <= 1'b0;
            @(negedge clk);
            if (forward.valid !== instr.valid)
                report_mismatch(name, "forward valid", $sformatf("%b", instr.valid),
                                $sformatf("%b", forward.valid));
            if (forward.ready !== exp_ready)
                report_mismatch(name, "forward ready", $sformatf("%b", exp_ready),
                                $sformatf("%b", forward.ready));
            if (exp_excp == '0 && forward.wreg !== exp_wb.wreg)
                report_mismatch(name, "forward wreg", $sformatf("%b", exp_wb.wreg),
                                $sformatf("%b", forward.wreg));
            if (exp_wb.wreg && forward.waddr !== instr.waddr)
                report_mismatch(name, "forward waddr", $sformatf("%h", instr.waddr),
                                $sformatf("%h", forward.waddr));
            if (exp_ready && exp_wb.wreg && forward.wdata !== exp_wdata)
                report_mismatch(name, "forward wdata", $sformatf("%h", exp_wdata),
                                $sformatf("%h", forward.wdata));
            if (advance_ready !== !access)
                report_mismatch(name, "first-cycle advance_ready_o", $sformatf("%b", !access),
                                $sformatf("%b", advance_ready));
            held = wb;

            @(posedge clk);
            advance <= 1'b1;
            @(negedge clk);
            if (advance_ready !== 1'b1)
                report_mismatch(name, "advance_ready_o", "1", $sformatf("%b", advance_ready));
            if (wb !== held)
                report_mismatch(name, "wb_o while held", $sformatf("%h", held),
                                $sformatf("%h", wb));

            @(posedge clk);
            advance <= 1'b0;
            ex      <= '0;
            @(negedge clk);
            exp_q.push_back(exp_wb);
            name_q.push_back(name);
            if (exp_q.size() > 1) begin
                check_wb(exp_q.pop_front(), name_q.pop_front());
            end
        end
    endtask

    task automatic check_wb(input mem_pkg::wb_t exp_wb, input string name);
        if (wb.valid !== exp_wb.valid) begin
            report_mismatch(name, "wb valid", $sformatf("%b", exp_wb.valid),
                            $sformatf("%b", wb.valid));
        end else if (exp_wb.valid) begin
            if (wb.excp !== exp_wb.excp)
                report_mismatch(name, "wb excp", $sformatf("%h", exp_wb.excp),
                                $sformatf("%h", wb.excp));
            if (wb.wreg !== exp_wb.wreg)
                report_mismatch(name, "wb wreg", $sformatf("%b", exp_wb.wreg),
                                $sformatf("%b", wb.wreg));
            if (exp_wb.wreg && wb.waddr !== exp_wb.waddr)
                report_mismatch(name, "wb waddr", $sformatf("%h", exp_wb.waddr),
                                $sformatf("%h", wb.waddr));
            if (exp_wb.wreg && wb.wdata !== exp_wb.wdata)
                report_mismatch(name, "wb wdata", $sformatf("%h", exp_wb.wdata),
                                $sformatf("%h", wb.wdata));
        end
    endtask

    // The instruction just advanced is dropped from mem2
    task automatic flush_pipe();
        mem_pkg::wb_t last;
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        last = exp_q.pop_back();
        last.valid = 1'b0;
        exp_q.push_back(last);
    endtask

    initial begin
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run went past %0d cycles", cycle_limit);
        $display("Something failed");
        $finish;
    end

    initial begin
        bit    ok;
        string kind;
        errors      = 0;
        cycles      = 0;
        cycle_limit = 0;
        rst         = 1'b1;
        ex          = '0;
        advance     = 1'b0;
        flush       = 1'b0;
        csr_plv     = '0;
        tlb_we      = 1'b0;
        tlb_windex  = '0;
        tlb_wentry  = '0;
        read_patterns(ok);
        if (!ok) begin
            $display("Could not open the pattern file dv/mem_patterns.txt");
            $display("Something failed");
            $finish;
        end else begin
            cycle_limit = 20 * lines.size();
            repeat (3) @(posedge clk);
            rst <= 1'b0;
            foreach (lines[i]) begin
                void'($sscanf(lines[i], "%s", kind));
                if (kind == "T") begin
                    fill_tlb(lines[i]);
                end else if (kind == "I" || kind == "B" || kind == "F") begin
                    run_instr(lines[i]);
                    if (kind == "F")
                        flush_pipe();
                end else begin
                    errors++;
                    $display("Unknown line kind in pattern file: %s", lines[i]);
                end
            end
            @(posedge clk);
            $display("Run complete: %0d errors, %0d pattern lines", errors, lines.size());
            if (errors == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

endmodule

// File: dv/mem_patterns.txt
# T idx e vppn ppn v d plv
# kind name op vaddr reg2 wreg waddr wdata trans in_excp plv exp_wdata exp_excp exp_fwd_ready
# kind I is an instruction, B a bubble, F an instruction flushed after it advances
I st_w1  st_w  00000100 11223344 0 00 00000000 0 0 0 00000000 00 1
I st_b1  st_b  00000101 000000a5 0 00 00000000 0 0 0 00000000 00 1
I st_h1  st_h  00000102 0000f00d 0 00 00000000 0 0 0 00000000 00 1
I ld_w1  ld_w  00000100 00000000 1 01 00000000 0 0 0 f00da544 00 0
I ld_b1  ld_b  00000101 00000000 1 02 00000000 0 0 0 ffffffa5 00 0
I ld_bu1 ld_bu 00000101 00000000 1 03 00000000 0 0 0 000000a5 00 0
I ld_h1  ld_h  00000102 00000000 1 04 00000000 0 0 0 fffff00d 00 0
I ld_hu1 ld_hu 00000100 00000000 1 05 00000000 0 0 0 0000a544 00 0
I alu1   none  00000000 00000000 1 06 0000beef 0 0 0 0000beef 00 1
T 0 1 00400 00002 1 1 3
T 1 1 00401 00003 0 0 0
T 2 1 00402 00002 1 0 3
T 3 1 00403 00003 1 1 0
I st_pa  st_w  00002040 cafef00d 0 00 00000000 0 0 0 00000000 00 1
I ld_tr  ld_w  00400040 00000000 1 07 00000000 1 0 0 cafef00d 00 0
I st_tr  st_w  00400044 12345678 0 00 00000000 1 0 3 00000000 00 1
I ld_pa  ld_w  00002044 00000000 1 08 00000000 0 0 0 12345678 00 0
I tlbr   ld_w  00500000 00000000 1 09 00000000 1 0 0 00000000 44 0
I pil    ld_w  00401000 00000000 1 09 00000000 1 0 0 00000000 40 0
I pis    st_w  00401008 deadbeef 0 00 00000000 1 0 0 00000000 20 1
I ppi    ld_w  00403000 00000000 1 09 00000000 1 0 3 00000000 10 0
I pme    st_w  00402048 deadbeef 0 00 00000000 1 0 0 00000000 08 1
I adem   st_w  80000100 deadbeef 0 00 00000000 0 0 3 00000000 02 1
I inexc  ld_w  00000100 00000000 1 09 00000000 0 1 0 00000000 01 0
I chk1   ld_w  00002048 00000000 1 0a 00000000 0 0 0 00000000 00 0
I chk2   ld_w  00000100 00000000 1 0a 00000000 0 0 0 f00da544 00 0
I sc_no  sc_w  00000200 aaaaaaaa 0 0b 00000000 0 0 0 00000000 00 1
I ld_s0  ld_w  00000200 00000000 1 0b 00000000 0 0 0 00000000 00 0
I ll     ll_w  00000200 00000000 1 0c 00000000 0 0 0 00000000 00 0
I sc_ok  sc_w  00000200 aaaaaaaa 0 0d 00000000 0 0 0 00000001 00 1
I sc_two sc_w  00000200 bbbbbbbb 0 0d 00000000 0 0 0 00000000 00 1
I ld_s1  ld_w  00000200 00000000 1 0e 00000000 0 0 0 aaaaaaaa 00 0
F fl     ld_w  00000100 00000000 1 0f 00000000 0 0 0 f00da544 00 0
I alu2   none  00000000 00000000 1 10 00001234 0 0 0 00001234 00 1
B end1   none  00000000 00000000 0 00 00000000 0 0 0 00000000 00 1

// File: compile.f
source/mem_pkg.sv
source/dtlb.sv
source/mem1_stage.sv
source/data_mem.sv
source/mem2_stage.sv
source/mem_subsys_top.sv
dv/mem_subsys_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module mem_subsys_tb -Mdir "$BUILD_DIR" -f compile.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vmem_subsys_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
